// File: logic/stripe_macros.svh
`ifndef STRIPE_MACROS_SVH
`define STRIPE_MACROS_SVH

// Number of memory channels striped per wide card beat
`define STRIPE_N_CHAN 4

// Width of one channel slice, also one user beat
`define STRIPE_DATA_BITS 32

// Byte keep bits per slice
`define STRIPE_KEEP_BITS (`STRIPE_DATA_BITS/8)

// Width of a command beat count
`define STRIPE_LEN_BITS 8

// Pending segment commands held ahead of the multiplexer
`define STRIPE_CMD_DEPTH 4

`endif

// File: logic/stripe_ctrl_pkg.sv
`default_nettype none

package stripe_ctrl_pkg;

  // Multiplexer FSM
  // ST_IDLE waits for a command, ST_MUX drains channels round-robin
  typedef enum logic [0:0] {
    ST_IDLE = 1'b0,
    ST_MUX  = 1'b1
  } mux_state_t;

endpackage

`default_nettype wire

// File: logic/stripe_cmd_pkg.sv
`default_nettype none

`include "stripe_macros.svh"

package stripe_cmd_pkg;

  // Segment end opcode, SEG_LAST raises user_tlast on the final beat
  typedef enum logic [0:0] {
    SEG_CONT = 1'b0,
    SEG_LAST = 1'b1
  } seg_end_t;

  // Number of user beats in a segment, minus one
  typedef logic [`STRIPE_LEN_BITS-1:0] seg_len_t;

endpackage

`default_nettype wire

// File: logic/chan_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module chan_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                         aclk,
  input  logic                         aresetn,
  // Write side, one slice of the wide card beat
  input  logic                         in_valid,
  output logic                         in_ready,
  input  logic [`STRIPE_DATA_BITS-1:0] in_data,
  input  logic [`STRIPE_KEEP_BITS-1:0] in_keep,
  // Read side, toward the multiplexer
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic [`STRIPE_DATA_BITS-1:0] out_data,
  output logic [`STRIPE_KEEP_BITS-1:0] out_keep
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  // Slice storage
  logic [`STRIPE_DATA_BITS-1:0] data_mem [DEPTH];
  logic [`STRIPE_KEEP_BITS-1:0] keep_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic push;
  logic pop;

  // Full refuses the push even when a pop happens in the same cycle
  assign in_ready  = (count_q != FULL_CNT);
  assign out_valid = (count_q != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // Oldest slice at the read pointer
  assign out_data = data_mem[rd_ptr_q];
  assign out_keep = keep_mem[rd_ptr_q];

  always_ff @(posedge aclk) begin
    if (push) begin
      data_mem[wr_ptr_q] <= in_data;
      keep_mem[wr_ptr_q] <= in_keep;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/stripe_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module stripe_cmd_queue (
  input  logic                     aclk,
  input  logic                     aresetn,
  // Command push from outside
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  stripe_cmd_pkg::seg_len_t cmd_len,
  input  stripe_cmd_pkg::seg_end_t cmd_end,
  // Head command toward the multiplexer
  output logic                     head_avail,
  output stripe_cmd_pkg::seg_len_t head_len,
  output stripe_cmd_pkg::seg_end_t head_end,
  input  logic                     head_take
);

  import stripe_cmd_pkg::*;

  localparam int DEPTH = `STRIPE_CMD_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

  seg_len_t len_mem [DEPTH];
  seg_end_t end_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign cmd_ready  = (count_q != CNT_W'(DEPTH));
  assign head_avail = (count_q != '0);
  assign push       = cmd_valid && cmd_ready;
  // Mux only strobes take with a head present, guard anyway
  assign pop        = head_take && head_avail;

  // Head visible the cycle after the push
  assign head_len = len_mem[rd_ptr_q];
  assign head_end = end_mem[rd_ptr_q];

  always_ff @(posedge aclk) begin
    if (push) begin
      len_mem[wr_ptr_q] <= cmd_len;
      end_mem[wr_ptr_q] <= cmd_end;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)      count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/stripe_src_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module stripe_src_mux (
  input  logic                                             aclk,
  input  logic                                             aresetn,
  // Head of the command queue
  input  logic                                             head_avail,
  input  stripe_cmd_pkg::seg_len_t                         head_len,
  input  stripe_cmd_pkg::seg_end_t                         head_end,
  output logic                                             head_take,
  // Channel FIFO read side
  input  logic [`STRIPE_N_CHAN-1:0]                        fifo_valid,
  input  logic [`STRIPE_N_CHAN-1:0][`STRIPE_DATA_BITS-1:0] fifo_data,
  input  logic [`STRIPE_N_CHAN-1:0][`STRIPE_KEEP_BITS-1:0] fifo_keep,
  output logic [`STRIPE_N_CHAN-1:0]                        fifo_ready,
  // Narrow user stream
  output logic                                             user_tvalid,
  input  logic                                             user_tready,
  output logic [`STRIPE_DATA_BITS-1:0]                     user_tdata,
  output logic [`STRIPE_KEEP_BITS-1:0]                     user_tkeep,
  output logic                                             user_tlast
);

  import stripe_ctrl_pkg::*;
  import stripe_cmd_pkg::*;

  localparam int SEL_W = (`STRIPE_N_CHAN > 1) ? $clog2(`STRIPE_N_CHAN) : 1;
  localparam logic [SEL_W-1:0] SEL_LAST = SEL_W'(`STRIPE_N_CHAN - 1);

  // -------------------------------------------------------------------
  // State and registers
  // -------------------------------------------------------------------
  mux_state_t       state_q;
  mux_state_t       state_d;
  logic [SEL_W-1:0] sel_q;
  logic [SEL_W-1:0] sel_d;
  seg_len_t         cnt_q;
  seg_len_t         cnt_d;
  // Latched command of the running segment
  seg_len_t         len_q;
  seg_end_t         end_q;

  logic last_beat;
  logic xfer;
  logic seg_done;

  // -------------------------------------------------------------------
  // User stream
  // -------------------------------------------------------------------
  // Selected channel only, so data holds while tready is low
  assign user_tvalid = (state_q == ST_MUX) && fifo_valid[sel_q];
  assign user_tdata  = fifo_data[sel_q];
  assign user_tkeep  = fifo_keep[sel_q];

  // Final beat of the segment, independent of tready
  assign last_beat  = (state_q == ST_MUX) && (cnt_q == len_q);
  assign user_tlast = last_beat && (end_q == SEG_LAST);

  assign xfer     = user_tvalid && user_tready;
  assign seg_done = xfer && last_beat;

  // Pop next command from idle, or back to back on the last beat
  assign head_take = head_avail && ((state_q == ST_IDLE) || seg_done);

  // -------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (head_avail) state_d = ST_MUX;
      end
      ST_MUX: begin
        // No follow-on command
        if (seg_done && !head_avail) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Beat counter within the segment
  always_comb begin
    cnt_d = cnt_q;
    if (head_take || seg_done) begin
      cnt_d = '0;
    end else if (xfer) begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  // Channel select and FIFO pops
  always_comb begin
    sel_d      = sel_q;
    fifo_ready = '0;
    if (xfer) begin
      fifo_ready[sel_q] = 1'b1;
      if (seg_done) begin
        // Drop the unused slices of this wide beat
        for (int i = 0; i < `STRIPE_N_CHAN; i++) begin
          if (i > int'(sel_q)) fifo_ready[i] = 1'b1;
        end
        sel_d = '0;
      end else if (sel_q == SEL_LAST) begin
        sel_d = '0;
      end else begin
        sel_d = sel_q + 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------
  // Registers
  // -------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      sel_q   <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      sel_q   <= sel_d;
      cnt_q   <= cnt_d;
    end
  end

  // Command fields, loaded with the pop
  always_ff @(posedge aclk) begin
    if (head_take) begin
      len_q <= head_len;
      end_q <= head_end;
    end
  end

endmodule

`default_nettype wire

// File: logic/stripe_src_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module stripe_src_top (
  input  logic                                           aclk,
  input  logic                                           aresetn,
  // Segment commands
  input  logic                                           cmd_valid,
  output logic                                           cmd_ready,
  input  stripe_cmd_pkg::seg_len_t                       cmd_len,
  input  stripe_cmd_pkg::seg_end_t                       cmd_end,
  // Wide card stream
  input  logic                                           card_tvalid,
  output logic                                           card_tready,
  input  logic [`STRIPE_N_CHAN*`STRIPE_DATA_BITS-1:0]    card_tdata,
  input  logic [`STRIPE_N_CHAN*`STRIPE_KEEP_BITS-1:0]    card_tkeep,
  // Narrow user stream
  output logic                                           user_tvalid,
  input  logic                                           user_tready,
  output logic [`STRIPE_DATA_BITS-1:0]                   user_tdata,
  output logic [`STRIPE_KEEP_BITS-1:0]                   user_tkeep,
  output logic                                           user_tlast
);

  import stripe_cmd_pkg::*;

  // -------------------------------------------------------------------
  // Internal wiring
  // -------------------------------------------------------------------
  logic                                             card_xfer;
  logic [`STRIPE_N_CHAN-1:0]                        fifo_in_ready;
  logic [`STRIPE_N_CHAN-1:0]                        fifo_out_valid;
  logic [`STRIPE_N_CHAN-1:0]                        fifo_out_ready;
  logic [`STRIPE_N_CHAN-1:0][`STRIPE_DATA_BITS-1:0] fifo_out_data;
  logic [`STRIPE_N_CHAN-1:0][`STRIPE_KEEP_BITS-1:0] fifo_out_keep;

  logic     head_avail;
  logic     head_take;
  seg_len_t head_len;
  seg_end_t head_end;

  // Whole beat only when every channel has room
  assign card_tready = &fifo_in_ready;
  assign card_xfer   = card_tvalid && card_tready;

  stripe_cmd_queue u_cmd_queue (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_len    (cmd_len),
    .cmd_end    (cmd_end),
    .head_avail (head_avail),
    .head_len   (head_len),
    .head_end   (head_end),
    .head_take  (head_take)
  );

  // One FIFO per channel slice, all written in the same cycle
  for (genvar i = 0; i < `STRIPE_N_CHAN; i++) begin : g_chan
    chan_fifo #(
      .DEPTH (4)
    ) u_chan_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (card_xfer),
      .in_ready  (fifo_in_ready[i]),
      .in_data   (card_tdata[i*`STRIPE_DATA_BITS +: `STRIPE_DATA_BITS]),
      .in_keep   (card_tkeep[i*`STRIPE_KEEP_BITS +: `STRIPE_KEEP_BITS]),
      .out_valid (fifo_out_valid[i]),
      .out_ready (fifo_out_ready[i]),
      .out_data  (fifo_out_data[i]),
      .out_keep  (fifo_out_keep[i])
    );
  end

  stripe_src_mux u_src_mux (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .head_avail  (head_avail),
    .head_len    (head_len),
    .head_end    (head_end),
    .head_take   (head_take),
    .fifo_valid  (fifo_out_valid),
    .fifo_data   (fifo_out_data),
    .fifo_keep   (fifo_out_keep),
    .fifo_ready  (fifo_out_ready),
    .user_tvalid (user_tvalid),
    .user_tready (user_tready),
    .user_tdata  (user_tdata),
    .user_tkeep  (user_tkeep),
    .user_tlast  (user_tlast)
  );

endmodule

`default_nettype wire

// File: verif/stripe_src_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module stripe_src_props (
  input logic                         aclk,
  input logic                         aresetn,
  input logic                         cmd_valid,
  input logic                         cmd_ready,
  input logic                         head_take,
  input logic                         user_tvalid,
  input logic                         user_tready,
  input logic [`STRIPE_DATA_BITS-1:0] user_tdata,
  input logic [`STRIPE_KEEP_BITS-1:0] user_tkeep,
  input logic                         user_tlast
);

  // Commands stored in the queue, the one held by the mux excluded
  int          pending_q;
  // Failed property count
  int unsigned prop_failures = 0;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pending_q <= 0;
    end else begin
      pending_q <= pending_q + int'(cmd_valid && cmd_ready) - int'(head_take);
    end
  end

  // ------------------------------------------------------------------
  // User stream holds its beat while stalled
  // ------------------------------------------------------------------
  hold_stalled_beat: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (user_tvalid && !user_tready) |=>
      (user_tvalid && $stable(user_tdata) && $stable(user_tkeep) && $stable(user_tlast))
  ) else begin
    prop_failures++;
    $error("user beat changed while user_tready was low");
  end

  // Quiet during reset and in the first cycle out of it
  quiet_in_reset: assert property (
    @(posedge aclk) (!aresetn && $past(!aresetn)) |-> !user_tvalid
  ) else begin
    prop_failures++;
    $error("user_tvalid high during reset");
  end

  quiet_after_reset: assert property (
    @(posedge aclk) $rose(aresetn) |-> !user_tvalid
  ) else begin
    prop_failures++;
    $error("user_tvalid high in the first cycle after reset");
  end

  // Queue only refuses commands when full
  ready_low_only_full: assert property (
    @(posedge aclk) disable iff (!aresetn)
    !cmd_ready |-> (pending_q == `STRIPE_CMD_DEPTH)
  ) else begin
    prop_failures++;
    $error("cmd_ready low with a queue that is not full");
  end

endmodule

bind stripe_src_top stripe_src_props u_props (
  .aclk        (aclk),
  .aresetn     (aresetn),
  .cmd_valid   (cmd_valid),
  .cmd_ready   (cmd_ready),
  .head_take   (head_take),
  .user_tvalid (user_tvalid),
  .user_tready (user_tready),
  .user_tdata  (user_tdata),
  .user_tkeep  (user_tkeep),
  .user_tlast  (user_tlast)
);

`default_nettype wire

// File: verif/stripe_src_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module stripe_src_tb;

  import stripe_cmd_pkg::*;

  localparam int N  = `STRIPE_N_CHAN;
  localparam int DW = `STRIPE_DATA_BITS;
  localparam int KW = `STRIPE_KEEP_BITS;
  // Roughly 1000 cycles of traffic with most of it stalled
  localparam int MAX_CYCLES = 4000;

  logic            aclk;
  logic            aresetn;
  logic            cmd_valid;
  logic            cmd_ready;
  seg_len_t        cmd_len;
  seg_end_t        cmd_end;
  logic            card_tvalid;
  logic            card_tready;
  logic [N*DW-1:0] card_tdata;
  logic [N*KW-1:0] card_tkeep;
  logic            user_tvalid;
  logic            user_tready;
  logic [DW-1:0]   user_tdata;
  logic [KW-1:0]   user_tkeep;
  logic            user_tlast;

  // Reference model fed from observed handshakes
  seg_len_t        sent_len_q [$];
  seg_end_t        sent_end_q [$];
  logic [N*DW-1:0] wide_data_q [$];
  logic [N*KW-1:0] wide_keep_q [$];
  logic [N*DW-1:0] cur_data;
  logic [N*KW-1:0] cur_keep;
  seg_len_t        seg_len;
  seg_end_t        seg_end;
  int              beat_idx;
  logic            seg_active = 1'b0;

  logic random_ready = 1'b0;
  logic card_stalled = 1'b0;
  int   seed;
  int   ready_seed;
  int   cycles = 0;
  int   mismatches = 0;
  int   failures = 0;

  stripe_src_top UUT (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_len     (cmd_len),
    .cmd_end     (cmd_end),
    .card_tvalid (card_tvalid),
    .card_tready (card_tready),
    .card_tdata  (card_tdata),
    .card_tkeep  (card_tkeep),
    .user_tvalid (user_tvalid),
    .user_tready (user_tready),
    .user_tdata  (user_tdata),
    .user_tkeep  (user_tkeep),
    .user_tlast  (user_tlast)
  );

  initial aclk = 1'b0;
  always #10 aclk = ~aclk;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatches++;
    $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
  endtask

  task automatic log_failure(input string what);
    failures++;
    $display("Failure: %s", what);
  endtask

  // ------------------------------------------------------------------
  // Prediction of one user beat
  // ------------------------------------------------------------------
  task automatic check_user_beat();
    logic [DW-1:0] exp_data;
    logic [KW-1:0] exp_keep;
    logic          exp_last;
    int            slice;
    if (!seg_active) begin
      if (sent_len_q.size() == 0) begin
        log_failure("user beat arrived with no pending command");
        return;
      end
      seg_len    = sent_len_q.pop_front();
      seg_end    = sent_end_q.pop_front();
      beat_idx   = 0;
      seg_active = 1'b1;
    end
    // Slice k mod N of wide beat k div N
    // New wide beat at slice 0
    slice = beat_idx % N;
    if (slice == 0) begin
      if (wide_data_q.size() == 0) begin
        log_failure("user beat arrived with no wide card beat behind it");
        return;
      end
      cur_data = wide_data_q.pop_front();
      cur_keep = wide_keep_q.pop_front();
    end
    exp_data = cur_data[slice*DW +: DW];
    exp_keep = cur_keep[slice*KW +: KW];
    exp_last = (beat_idx == int'(seg_len)) && (seg_end == SEG_LAST);
    assert (user_tdata == exp_data)
      else report_mismatch("user_tdata", exp_data, user_tdata);
    assert (user_tkeep == exp_keep)
      else report_mismatch("user_tkeep", 32'(exp_keep), 32'(user_tkeep));
    assert (user_tlast == exp_last)
      else report_mismatch("user_tlast", 32'(exp_last), 32'(user_tlast));
    // Rest of a partial wide beat is dropped with the segment
    if (beat_idx == int'(seg_len)) begin
      seg_active = 1'b0;
    end else begin
      beat_idx++;
    end
  endtask

  // Cycle limit and handshake monitor
  always @(posedge aclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
    if (aresetn) begin
      if (cmd_valid && cmd_ready) begin
        sent_len_q.push_back(cmd_len);
        sent_end_q.push_back(cmd_end);
      end
      if (card_tvalid && card_tready) begin
        wide_data_q.push_back(card_tdata);
        wide_keep_q.push_back(card_tkeep);
      end
      if (random_ready && card_tvalid && !card_tready) card_stalled = 1'b1;
      if (user_tvalid && user_tready) check_user_beat();
    end
  end

  // Sink back-pressure with ready in 1 of 4 cycles when enabled
  always @(negedge aclk) begin
    if (random_ready) begin
      user_tready = (($random(ready_seed) & 3) == 0);
    end else begin
      user_tready = 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // Drivers entered and left on a falling edge
  // ------------------------------------------------------------------
  task automatic push_cmd(input int len, input seg_end_t end_op);
    cmd_valid = 1'b1;
    cmd_len   = seg_len_t'(len);
    cmd_end   = end_op;
    while (!cmd_ready) @(negedge aclk);
    @(negedge aclk);
    cmd_valid = 1'b0;
  endtask

  task automatic send_wide();
    logic [31:0] rnd;
    int          i;
    card_tvalid = 1'b1;
    for (i = 0; i < N; i++) begin
      card_tdata[i*DW +: DW] = $random(seed);
      rnd = $random(seed);
      card_tkeep[i*KW +: KW] = rnd[KW-1:0];
    end
    while (!card_tready) @(negedge aclk);
    @(negedge aclk);
    card_tvalid = 1'b0;
  endtask

  // Command plus its ceil((len+1)/N) wide beats
  task automatic run_segment(input int len, input seg_end_t end_op);
    push_cmd(len, end_op);
    repeat (len / N + 1) send_wide();
  endtask

  task automatic wait_drain();
    while (seg_active || sent_len_q.size() != 0) @(negedge aclk);
  endtask

  initial begin
    logic [31:0] rnd;
    int          i;
    int          prop_fails;
    seed        = 75075;
    ready_seed  = seed;
    aresetn     = 1'b0;
    cmd_valid   = 1'b0;
    cmd_len     = '0;
    cmd_end     = SEG_CONT;
    card_tvalid = 1'b0;
    card_tdata  = '0;
    card_tkeep  = '0;
    user_tready = 1'b1;
    repeat (4) @(negedge aclk);
    aresetn = 1'b1;

    // Idle outputs straight out of reset
    assert (!user_tvalid) else report_mismatch("user_tvalid", 32'h0, 32'(user_tvalid));
    assert (cmd_ready) else report_mismatch("cmd_ready", 32'h1, 32'(cmd_ready));
    assert (card_tready) else report_mismatch("card_tready", 32'h1, 32'(card_tready));

    // Five commands without data
    // One goes to the mux and four fill the queue
    push_cmd(3, SEG_LAST);
    push_cmd(7, SEG_CONT);
    push_cmd(11, SEG_LAST);
    push_cmd(15, SEG_CONT);
    push_cmd(3, SEG_LAST);
    assert (!cmd_ready) else report_mismatch("cmd_ready", 32'h0, 32'(cmd_ready));
    // Whole wide beats only in plain round-robin
    repeat (11) send_wide();
    wait_drain();

    // Segments that end inside a wide beat
    run_segment(0, SEG_LAST);
    run_segment(4, SEG_CONT);
    run_segment(5, SEG_LAST);
    run_segment(6, SEG_LAST);
    run_segment(1, SEG_CONT);
    run_segment(2, SEG_LAST);
    wait_drain();

    // Random lengths under sink back-pressure
    random_ready = 1'b1;
    for (i = 0; i < 24; i++) begin
      rnd = $random(seed);
      run_segment(int'(rnd[3:0]), rnd[4] ? SEG_LAST : SEG_CONT);
    end
    wait_drain();
    random_ready = 1'b0;

    assert (card_stalled)
      else log_failure("card_tready never fell under back-pressure");

    prop_fails = int'(UUT.u_props.prop_failures);
    $display("Result: %0d value mismatches, %0d other failures, %0d property failures",
             mismatches, failures, prop_fails);
    if (mismatches + failures + prop_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/stripe_ctrl_pkg.sv
logic/stripe_cmd_pkg.sv
logic/chan_fifo.sv
logic/stripe_cmd_queue.sv
logic/stripe_src_mux.sv
logic/stripe_src_top.sv
verif/stripe_src_props.sv
verif/stripe_src_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module stripe_src_tb \
  -f sources.f -o stripe_src_sim > build.log 2>&1 \
  && ./obj_dir/stripe_src_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "No result in log"; exit 1; }
exit 0
